// ==== fwd_extend.f ====
hw/fwd_extend_pkg.sv
hw/fwd_addr_stage.sv
hw/item_delay_line.sv
hw/extend_decision.sv
hw/interval_update.sv
hw/mem_request.sv
hw/fwd_extend_top.sv
testbench/fwd_extend_assertions.sv
testbench/tb_fwd_extend.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fwd_extend
FILELIST  ?= fwd_extend.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Finished with no errors" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/fwd_extend_stimulus.txt ====
// line 1: primary, item count; then three lines per item (all hex):
// in: status query ptr read x0 x1 x2 info fwd min bx | ok: A C G T as x0 x1 x2
// exp: we addr retv ret qstat qpos dv addr_k addr_l stat ptr x0 x1 x2 info fwd
1000 7
0 2 0 1 0 1 2000 0 0 1 0
0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 1 0 3f0 1 0 0 1 2000 0 0
1 1 3 2 5 1800 400 22 10 20 7
1 2 3 4 5 6 11 1900 100 7 8 9
1 3 0 0 1 11 1 310 330 1 4 11 1900 100 11 11
1 0 5 3 2 300 40 9 20 30 0
a b 40 4 5 6 1 2 3 3 310 10
1 5 0 0 2 20 0 0 0 2 6 2 300 40 9 20
1 4 1 4 1 50 8 3 30 1 2
0 0 0 0 0 0 0 0 0 0 0 0
1 1 0 0 2 30 0 0 0 2 2 1 50 8 3 30
1 2 7 5 4 60 6 1e5 65 1 0
0 0 0 0 0 0 0 0 0 0 0 0
1 7 1 65 4 65 0 0 0 4 8 4 60 6 1e5 65
2 0 2 6 0 70 3 ab 40 2 1
0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 2b 4 40 0 0 0 4 2 0 70 3 ab 40
1 3 9 7 21 900 80 5 5 4 3
33 950 80 1 2 3 4 5 6 7 8 9
0 0 0 0 1 6 1 120 130 1 9 33 950 80 6 6

// ==== testbench/tb_fwd_extend.sv ====
module tb_fwd_extend;
	timeunit 1ns;
	timeprecision 1ps;
	import fwd_extend_pkg::*;

	localparam int REC       = 39;  // words per item record
	localparam int EXP       = 23;  // first expected word
	localparam int MAX_ITEMS = 16;
	localparam int MAX_SLOTS = 512;
	localparam int RUN_LIMIT = 300;

	logic Clk_32UI = 1'b0;
	logic reset_BWT_extend, stall_i;
	logic [BOUND_W-1:0] primary_i, occ_k_o, occ_l_o;
	logic [BOUND_W-1:0] hold_occ_k, hold_occ_l;
	fwd_item_t item_i, item_o, hold_item;
	occ_result_t occ_i;
	curr_write_t curr_o, hold_curr;
	logic ret_valid_o, hold_ret_valid;
	logic [POS_W-1:0] ret_o;
	logic [READ_NUM_W-1:0] ret_read_num_o;
	query_req_t query_o, hold_query;
	dram_req_t dram_o, hold_dram;

	logic [63:0] stim [2+REC*MAX_ITEMS];
	int slot_item [MAX_SLOTS]; // item entered at each unstalled edge
	int ucycle = 0;
	int last_u = 0;
	int items_done = 0;
	int n_items = 0;
	int error_count = 0;
	logic armed = 1'b0;

	fwd_extend_top uut (.*);

	always #2 Clk_32UI = ~Clk_32UI;

	always @(posedge Clk_32UI) begin
		if (reset_BWT_extend && !stall_i) ucycle <= ucycle + 1;
	end

	function automatic fwd_item_t item_from_file(input int n);
		fwd_item_t f;
		int b;
		b = 2 + n*REC;
		f.status     = fwd_status_e'(stim[b][5:0]);
		f.query      = base_e'(stim[b+1][7:0]);
		f.ptr_curr   = stim[b+2][POS_W-1:0];
		f.read_num   = stim[b+3][READ_NUM_W-1:0];
		f.ik.iv.x0   = stim[b+4];
		f.ik.iv.x1   = stim[b+5];
		f.ik.iv.x2   = stim[b+6];
		f.ik.info    = stim[b+7];
		f.forward_i  = stim[b+8][POS_W-1:0];
		f.min_intv   = stim[b+9][POS_W-1:0];
		f.backward_x = stim[b+10][POS_W-1:0];
		return f;
	endfunction

	function automatic fwd_item_t bubble_item();
		fwd_item_t f;
		f = '0;
		f.status = BUBBLE;
		return f;
	endfunction

	function automatic int slot_lookup(input int e);
		return (e >= 0 && e < MAX_SLOTS) ? slot_item[e] : -1;
	endfunction

	// expected lookup bound, one below the interval end, one more past primary
	function automatic logic [BOUND_W-1:0] lookup_bound(input logic [BOUND_W-1:0] b,
			input logic [BOUND_W-1:0] primary);
		logic [BOUND_W-1:0] r;
		r = b - 64'd1;
		if (r >= primary) begin
			r = r - 64'd1;
		end
		return r;
	endfunction

	// occurrence unit model, result for the item that entered 12 edges back
	function automatic occ_result_t occ_for_slot(input int e);
		occ_result_t r;
		int idx;
		int b;
		r = '0;
		idx = slot_lookup(e);
		if (idx >= 0) begin
			b = 2 + idx*REC + 11;
			for (int c = 0; c < 4; c++) begin
				r[c].x0 = stim[b + 3*c];
				r[c].x1 = stim[b + 3*c + 1];
				r[c].x2 = stim[b + 3*c + 2];
			end
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [511:0] actual,
			input logic [511:0] expected);
		if (actual !== expected) begin
			error_count++;
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("Finished with errors");
			$fatal(1, "value mismatch");
		end
	endtask

	// ----------------------------------------------------------------------
	// per-stage checks after an unstalled edge
	task automatic check_stage_outputs(input int u);
		int idx;
		int ib;
		int eb;
		idx = slot_lookup(u);
		ib  = 2 + idx*REC;
		if (idx >= 0) begin
			check_value("occ_k_o", 512'(occ_k_o), 512'(lookup_bound(stim[ib+5], primary_i)));
			check_value("occ_l_o", 512'(occ_l_o),
				512'(lookup_bound(stim[ib+5] + stim[ib+6], primary_i)));
		end
		idx = slot_lookup(u - 13);
		ib  = 2 + idx*REC;
		eb  = ib + EXP;
		if (idx < 0) begin
			check_value("curr_o.we", 512'(curr_o.we), 512'(0));
			check_value("ret_valid_o", 512'(ret_valid_o), 512'(0));
		end else begin
			check_value("curr_o.we", 512'(curr_o.we), 512'(stim[eb][0]));
			if (stim[eb][0]) begin
				check_value("curr_o.addr", 512'(curr_o.addr), 512'(stim[eb+1][POS_W-1:0]));
				check_value("curr_o.read_num", 512'(curr_o.read_num),
					512'(stim[ib+3][READ_NUM_W-1:0]));
				check_value("curr_o.data", 512'(curr_o.data),
					512'({stim[ib+7], stim[ib+6], stim[ib+5], stim[ib+4]}));
			end
			check_value("ret_valid_o", 512'(ret_valid_o), 512'(stim[eb+2][0]));
			if (stim[eb+2][0]) begin
				check_value("ret_o", 512'(ret_o), 512'(stim[eb+3][POS_W-1:0]));
				check_value("ret_read_num_o", 512'(ret_read_num_o),
					512'(stim[ib+3][READ_NUM_W-1:0]));
			end
		end
		idx = slot_lookup(u - 15);
		ib  = 2 + idx*REC;
		eb  = ib + EXP;
		if (idx < 0) begin
			check_value("query_o.status", 512'(query_o.status), 512'(BUBBLE));
		end else begin
			check_value("query_o.status", 512'(query_o.status), 512'(stim[eb+4][5:0]));
			check_value("query_o.read_num", 512'(query_o.read_num),
				512'(stim[ib+3][READ_NUM_W-1:0]));
			check_value("query_o.position", 512'(query_o.position),
				512'(stim[eb+5][POS_W-1:0]));
		end
		idx = slot_lookup(u - 16);
		ib  = 2 + idx*REC;
		eb  = ib + EXP;
		if (idx < 0) begin
			check_value("dram_o.valid", 512'(dram_o.valid), 512'(0));
			check_value("item_o.status", 512'(item_o.status), 512'(BUBBLE));
		end else begin
			check_value("dram_o.valid", 512'(dram_o.valid), 512'(stim[eb+6][0]));
			check_value("dram_o.addr_k", 512'(dram_o.addr_k), 512'(stim[eb+7][ADDR_W-1:0]));
			check_value("dram_o.addr_l", 512'(dram_o.addr_l), 512'(stim[eb+8][ADDR_W-1:0]));
			check_value("item_o.status", 512'(item_o.status), 512'(stim[eb+9][5:0]));
			check_value("item_o.ptr_curr", 512'(item_o.ptr_curr), 512'(stim[eb+10][POS_W-1:0]));
			check_value("item_o.ik", 512'(item_o.ik),
				512'({stim[eb+14], stim[eb+13], stim[eb+12], stim[eb+11]}));
			check_value("item_o.forward_i", 512'(item_o.forward_i),
				512'(stim[eb+15][POS_W-1:0]));
			check_value("item_o.read_num", 512'(item_o.read_num),
				512'(stim[ib+3][READ_NUM_W-1:0]));
			check_value("item_o.min_intv", 512'(item_o.min_intv), 512'(stim[ib+9][POS_W-1:0]));
			check_value("item_o.query", 512'(item_o.query), 512'(stim[ib+1][7:0]));
			check_value("item_o.backward_x", 512'(item_o.backward_x),
				512'(stim[ib+10][POS_W-1:0]));
			items_done++;
		end
	endtask

	always @(negedge Clk_32UI) begin
		if (reset_BWT_extend) begin
			if (ucycle != last_u) begin
				check_stage_outputs(ucycle);
				last_u = ucycle;
			end else if (armed) begin // stalled, everything must hold
				check_value("occ_k_o (stall)", 512'(occ_k_o), 512'(hold_occ_k));
				check_value("occ_l_o (stall)", 512'(occ_l_o), 512'(hold_occ_l));
				check_value("curr_o (stall)", 512'(curr_o), 512'(hold_curr));
				check_value("ret_valid_o (stall)", 512'(ret_valid_o), 512'(hold_ret_valid));
				check_value("query_o (stall)", 512'(query_o), 512'(hold_query));
				check_value("dram_o (stall)", 512'(dram_o), 512'(hold_dram));
				check_value("item_o (stall)", 512'(item_o), 512'(hold_item));
			end
			hold_occ_k     = occ_k_o;
			hold_occ_l     = occ_l_o;
			hold_curr      = curr_o;
			hold_ret_valid = ret_valid_o;
			hold_query     = query_o;
			hold_dram      = dram_o;
			hold_item      = item_o;
			armed          = 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// feed all items back to back, optionally with stall windows
	task automatic run_items(input logic with_stall);
		int cyc;
		int next;
		int target;
		cyc    = 0;
		next   = 0;
		target = items_done + n_items;
		while (items_done < target) begin
			@(posedge Clk_32UI);
			#1;
			stall_i = with_stall && ((cyc >= 3 && cyc < 7) || (cyc >= 15 && cyc < 18));
			if (!stall_i) begin
				if (next < n_items && ucycle + 1 < MAX_SLOTS) begin
					item_i = item_from_file(next);
					slot_item[ucycle + 1] = next;
					next++;
				end else begin
					item_i = bubble_item();
				end
			end
			occ_i = occ_for_slot(ucycle - 12);
			cyc++;
			if (cyc > RUN_LIMIT) begin
				$display("Timeout: not all items reached the outputs");
				$display("Finished with errors");
				$fatal(1, "timeout");
			end
		end
		stall_i = 1'b0;
	endtask

	initial begin
		reset_BWT_extend = 1'b0;
		stall_i   = 1'b0;
		primary_i = '0;
		item_i    = bubble_item();
		occ_i     = '0;
		for (int s = 0; s < MAX_SLOTS; s++) slot_item[s] = -1;
		$readmemh("testbench/fwd_extend_stimulus.txt", stim);
		primary_i = stim[0];
		n_items   = int'(stim[1]);
		if (n_items < 1 || n_items > MAX_ITEMS) begin
			$display("Stimulus file holds no usable item count");
			$display("Finished with errors");
			$fatal(1, "bad stimulus");
		end
		for (int c = 0; c < 3; c++) @(posedge Clk_32UI);
		#1 reset_BWT_extend = 1'b1;
		@(negedge Clk_32UI);
		check_value("dram_o.valid", 512'(dram_o.valid), 512'(0));
		check_value("curr_o.we", 512'(curr_o.we), 512'(0));
		check_value("ret_valid_o", 512'(ret_valid_o), 512'(0));
		check_value("query_o.status", 512'(query_o.status), 512'(BUBBLE));
		check_value("item_o.status", 512'(item_o.status), 512'(BUBBLE));
		run_items(1'b0);
		run_items(1'b1); // same items, same expected results
		if (error_count == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("Finished with errors");
			$fatal(1, "checks failed");
		end
	end

endmodule

// ==== testbench/fwd_extend_assertions.sv ====
module fwd_extend_assertions (
	input logic                      Clk_32UI,
	input logic                      reset_BWT_extend,
	input logic                      stall_i,
	input fwd_extend_pkg::dram_req_t dram_i,
	input fwd_extend_pkg::fwd_item_t item_i,
	input fwd_extend_pkg::fwd_item_t dec_item_i,
	input fwd_extend_pkg::curr_write_t curr_i,
	input logic                      ret_valid_i
);
	timeunit 1ns;
	timeprecision 1ps;
	import fwd_extend_pkg::*;

	// ----------------------------------------------------------------------
	// output consistency
	assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		dram_i.valid |-> item_i.status == F_RUN)
		else $error("dram request without a running item");

	assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		ret_valid_i |-> dec_item_i.status == BCK_INI)
		else $error("return value without backward hand-over");

	// frozen pipeline
	assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		stall_i |=> $stable(dram_i) && $stable(ret_valid_i) && $stable(curr_i.we)
			&& $stable(item_i.status))
		else $error("output changed during stall");

endmodule

bind fwd_extend_top fwd_extend_assertions u_assert (
	.Clk_32UI         (Clk_32UI),
	.reset_BWT_extend (reset_BWT_extend),
	.stall_i          (stall_i),
	.dram_i           (dram_o),
	.item_i           (item_o),
	.dec_item_i       (dec_item),
	.curr_i           (curr_o),
	.ret_valid_i      (ret_valid_o)
);

// ==== hw/fwd_extend_top.sv ====
module fwd_extend_top (
	input  logic                                   Clk_32UI,
	input  logic                                   reset_BWT_extend,
	input  logic                                   stall_i,
	input  logic [fwd_extend_pkg::BOUND_W-1:0]     primary_i,
	input  fwd_extend_pkg::fwd_item_t              item_i,
	output logic [fwd_extend_pkg::BOUND_W-1:0]     occ_k_o,
	output logic [fwd_extend_pkg::BOUND_W-1:0]     occ_l_o,
	input  fwd_extend_pkg::occ_result_t            occ_i,
	output fwd_extend_pkg::curr_write_t            curr_o,
	output logic                                   ret_valid_o,
	output logic [fwd_extend_pkg::POS_W-1:0]       ret_o,
	output logic [fwd_extend_pkg::READ_NUM_W-1:0]  ret_read_num_o,
	output fwd_extend_pkg::query_req_t             query_o,
	output fwd_extend_pkg::dram_req_t              dram_o,
	output fwd_extend_pkg::fwd_item_t              item_o
);
	import fwd_extend_pkg::*;

	fwd_item_t          addr_item;  // after entry stage
	fwd_item_t          occ_item;   // aligned with occ_i
	fwd_item_t          dec_item;   // after decision
	fwd_item_t          upd_item;   // after interval update
	bi_interval_t       sel;
	logic               update;
	logic [BOUND_W-1:0] k_raw, l_raw, k_dec, l_dec;

	// ----------------------------------------------------------------------
	// stage chain
	fwd_addr_stage u_addr (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.item_i           (item_i),
		.primary_i        (primary_i),
		.item_o           (addr_item),
		.occ_k_o          (occ_k_o),
		.occ_l_o          (occ_l_o)
	);

	item_delay_line #(.DEPTH(OCC_LATENCY)) u_delay (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.item_i           (addr_item),
		.item_o           (occ_item)
	);

	extend_decision u_decide (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.item_i           (occ_item),
		.occ_i            (occ_i),
		.item_o           (dec_item),
		.sel_o            (sel),
		.update_o         (update),
		.curr_o           (curr_o),
		.ret_valid_o      (ret_valid_o),
		.ret_o            (ret_o),
		.ret_read_num_o   (ret_read_num_o)
	);

	interval_update u_update (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.item_i           (dec_item),
		.sel_i            (sel),
		.update_i         (update),
		.item_o           (upd_item),
		.k_raw_o          (k_raw),
		.l_raw_o          (l_raw),
		.k_dec_o          (k_dec),
		.l_dec_o          (l_dec),
		.query_o          (query_o)
	);

	mem_request u_mem (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.item_i           (upd_item),
		.k_raw_i          (k_raw),
		.l_raw_i          (l_raw),
		.k_dec_i          (k_dec),
		.l_dec_i          (l_dec),
		.primary_i        (primary_i),
		.dram_o           (dram_o),
		.item_o           (item_o)
	);

endmodule

// ==== hw/mem_request.sv ====
module mem_request (
	input  logic                                 Clk_32UI,
	input  logic                                 reset_BWT_extend,
	input  logic                                 stall_i,
	input  fwd_extend_pkg::fwd_item_t            item_i,
	input  logic [fwd_extend_pkg::BOUND_W-1:0]   k_raw_i,
	input  logic [fwd_extend_pkg::BOUND_W-1:0]   l_raw_i,
	input  logic [fwd_extend_pkg::BOUND_W-1:0]   k_dec_i,
	input  logic [fwd_extend_pkg::BOUND_W-1:0]   l_dec_i,
	input  logic [fwd_extend_pkg::BOUND_W-1:0]   primary_i,
	output fwd_extend_pkg::dram_req_t            dram_o,
	output fwd_extend_pkg::fwd_item_t            item_o
);
	import fwd_extend_pkg::*;

	logic [BOUND_W-1:0] k_bound;
	logic [BOUND_W-1:0] l_bound;
	logic               active;
	dram_req_t          dram_q;
	fwd_item_t          item_q;

	assign k_bound = (k_raw_i >= primary_i) ? k_dec_i : k_raw_i;
	assign l_bound = (l_raw_i >= primary_i) ? l_dec_i : l_raw_i;
	assign active  = (item_i.status == F_INIT) || (item_i.status == F_RUN);

	// ----------------------------------------------------------------------
	// occ line fetch for the next step
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			dram_q.valid  <= 1'b0;
			item_q.status <= BUBBLE;
		end else if (!stall_i) begin
			dram_q.valid  <= active; // broken reads need no fetch
			dram_q.addr_k <= active ? line_addr(k_bound) : '0;
			dram_q.addr_l <= active ? line_addr(l_bound) : '0;
			item_q        <= item_i;
			if (item_i.status == F_INIT) begin
				item_q.status <= F_RUN;
			end
		end
	end

	assign dram_o = dram_q;
	assign item_o = item_q;

endmodule

// ==== hw/interval_update.sv ====
module interval_update (
	input  logic                                 Clk_32UI,
	input  logic                                 reset_BWT_extend,
	input  logic                                 stall_i,
	input  fwd_extend_pkg::fwd_item_t            item_i,
	input  fwd_extend_pkg::bi_interval_t         sel_i,
	input  logic                                 update_i,
	output fwd_extend_pkg::fwd_item_t            item_o,
	output logic [fwd_extend_pkg::BOUND_W-1:0]   k_raw_o,
	output logic [fwd_extend_pkg::BOUND_W-1:0]   l_raw_o,
	output logic [fwd_extend_pkg::BOUND_W-1:0]   k_dec_o,
	output logic [fwd_extend_pkg::BOUND_W-1:0]   l_dec_o,
	output fwd_extend_pkg::query_req_t           query_o
);
	import fwd_extend_pkg::*;

	fwd_item_t          item_d;
	logic [BOUND_W-1:0] k_raw_d;
	logic [BOUND_W-1:0] l_raw_d;

	fwd_item_t          item1_q;
	logic [BOUND_W-1:0] k_raw1_q, l_raw1_q, k_dec1_q, l_dec1_q;
	fwd_item_t          item2_q;
	logic [BOUND_W-1:0] k_raw2_q, l_raw2_q, k_dec2_q, l_dec2_q;
	query_req_t         query_q;

	// ----------------------------------------------------------------------
	// ik = ok[c], ik.info = i + 1, i++
	always_comb begin
		item_d = item_i;
		if (item_i.status == F_RUN && update_i) begin
			item_d.ik.iv    = sel_i;
			item_d.ik.info  = BOUND_W'(item_i.forward_i) + 1'b1;
			item_d.forward_i = item_i.forward_i + 1'b1;
		end
	end

	assign k_raw_d = item_d.ik.iv.x1 - 1'b1; // next lookup bounds
	assign l_raw_d = k_raw_d + item_d.ik.iv.x2;

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			item1_q.status <= BUBBLE;
			item2_q.status <= BUBBLE;
			query_q.status <= BUBBLE;
		end else if (!stall_i) begin
			item1_q  <= item_d;
			k_raw1_q <= k_raw_d;
			l_raw1_q <= l_raw_d;
			k_dec1_q <= k_raw_d - 1'b1; // primary correction picked later
			l_dec1_q <= l_raw_d - 1'b1;

			item2_q  <= item1_q;
			k_raw2_q <= k_raw1_q;
			l_raw2_q <= l_raw1_q;
			k_dec2_q <= k_dec1_q;
			l_dec2_q <= l_dec1_q;

			query_q.status   <= item1_q.status; // one cycle ahead of dram
			query_q.read_num <= item1_q.read_num;
			query_q.position <= item1_q.forward_i;
		end
	end

	assign item_o  = item2_q;
	assign k_raw_o = k_raw2_q;
	assign l_raw_o = l_raw2_q;
	assign k_dec_o = k_dec2_q;
	assign l_dec_o = l_dec2_q;
	assign query_o = query_q;

endmodule

// ==== hw/extend_decision.sv ====
module extend_decision (
	input  logic                                   Clk_32UI,
	input  logic                                   reset_BWT_extend,
	input  logic                                   stall_i,
	input  fwd_extend_pkg::fwd_item_t              item_i,
	input  fwd_extend_pkg::occ_result_t            occ_i,
	output fwd_extend_pkg::fwd_item_t              item_o,
	output fwd_extend_pkg::bi_interval_t           sel_o,
	output logic                                   update_o,
	output fwd_extend_pkg::curr_write_t            curr_o,
	output logic                                   ret_valid_o,
	output logic [fwd_extend_pkg::POS_W-1:0]       ret_o,
	output logic [fwd_extend_pkg::READ_NUM_W-1:0]  ret_read_num_o
);
	import fwd_extend_pkg::*;

	logic [7:0]       query_code;
	logic [1:0]       base_idx;
	bi_interval_t     cand;
	fwd_item_t        item_d;
	logic             update_d;
	logic             we_d;
	logic             ret_valid_d;

	fwd_item_t        item_q;
	bi_interval_t     sel_q;
	logic             update_q;
	curr_write_t      curr_q;
	logic             ret_valid_q;
	logic [POS_W-1:0] ret_q;
	logic [READ_NUM_W-1:0] ret_read_num_q;

	assign query_code = item_i.query;
	assign base_idx   = 2'd3 - query_code[1:0]; // complement base
	assign cand       = occ_i[base_idx];

	// ----------------------------------------------------------------------
	// continue or break
	always_comb begin
		item_d      = item_i;
		update_d    = 1'b0;
		we_d        = 1'b0;
		ret_valid_d = 1'b0;
		case (item_i.status)
			F_RUN: begin
				if (item_i.query > BASE_T) begin
					we_d            = 1'b1; // ambiguous base ends the extension
					item_d.ptr_curr = item_i.ptr_curr + 1'b1;
					item_d.status   = F_BREAK;
				end else if (cand.x2 != item_i.ik.iv.x2) begin
					we_d            = 1'b1; // old ik is superseded
					item_d.ptr_curr = item_i.ptr_curr + 1'b1;
					if (cand.x2 < BOUND_W'(item_i.min_intv)) begin
						item_d.status = F_BREAK;
					end else begin
						update_d = 1'b1;
					end
				end else begin
					update_d = 1'b1; // same size, no curr entry
				end
			end
			F_BREAK: begin
				if (item_i.forward_i == POS_W'(SEQ_LEN)) begin
					we_d            = 1'b1;
					item_d.ptr_curr = item_i.ptr_curr + 1'b1;
				end
				ret_valid_d   = 1'b1;
				item_d.status = BCK_INI; // hand over to backward search
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			item_q.status <= BUBBLE;
			curr_q.we     <= 1'b0;
			ret_valid_q   <= 1'b0;
			update_q      <= 1'b0;
		end else if (!stall_i) begin
			item_q          <= item_d;
			sel_q           <= cand;
			update_q        <= update_d;
			curr_q.we       <= we_d;
			curr_q.read_num <= item_i.read_num;
			curr_q.addr     <= item_i.ptr_curr; // pointer before the advance
			curr_q.data     <= item_i.ik;
			ret_valid_q     <= ret_valid_d;
			ret_q           <= item_i.ik.info[POS_W-1:0];
			ret_read_num_q  <= item_i.read_num;
		end
	end

	assign item_o         = item_q;
	assign sel_o          = sel_q;
	assign update_o       = update_q;
	assign curr_o         = curr_q;
	assign ret_valid_o    = ret_valid_q;
	assign ret_o          = ret_q;
	assign ret_read_num_o = ret_read_num_q;

endmodule

// ==== hw/item_delay_line.sv ====
module item_delay_line #(
	parameter int DEPTH = fwd_extend_pkg::OCC_LATENCY
) (
	input  logic                      Clk_32UI,
	input  logic                      reset_BWT_extend,
	input  logic                      stall_i,
	input  fwd_extend_pkg::fwd_item_t item_i,
	output fwd_extend_pkg::fwd_item_t item_o
);
	import fwd_extend_pkg::*;

	fwd_item_t stage_q [DEPTH]; // one slot per occurrence-unit cycle

	// ----------------------------------------------------------------------
	// shift register, frozen as a whole by stall
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			for (int s = 0; s < DEPTH; s++) begin
				stage_q[s].status <= BUBBLE;
			end
		end else if (!stall_i) begin
			stage_q[0] <= item_i;
			for (int s = 1; s < DEPTH; s++) begin
				stage_q[s] <= stage_q[s-1];
			end
		end
	end

	assign item_o = stage_q[DEPTH-1]; // lines up with occ result

endmodule

// ==== hw/fwd_addr_stage.sv ====
module fwd_addr_stage (
	input  logic                                 Clk_32UI,
	input  logic                                 reset_BWT_extend,
	input  logic                                 stall_i,
	input  fwd_extend_pkg::fwd_item_t            item_i,
	input  logic [fwd_extend_pkg::BOUND_W-1:0]   primary_i,
	output fwd_extend_pkg::fwd_item_t            item_o,
	output logic [fwd_extend_pkg::BOUND_W-1:0]   occ_k_o,
	output logic [fwd_extend_pkg::BOUND_W-1:0]   occ_l_o
);
	import fwd_extend_pkg::*;

	fwd_item_t          item_q;
	fwd_status_e        status_d;
	logic [BOUND_W-1:0] k_raw;
	logic [BOUND_W-1:0] l_raw;
	logic [BOUND_W-1:0] occ_k_q;
	logic [BOUND_W-1:0] occ_l_q;

	// ----------------------------------------------------------------------
	// forward control
	always_comb begin
		status_d = item_i.status;
		if (item_i.status == F_RUN && item_i.forward_i >= POS_W'(SEQ_LEN)) begin
			status_d = F_BREAK; // read fully extended
		end
	end

	// ----------------------------------------------------------------------
	// lookup bounds for the occurrence unit
	assign k_raw = item_i.ik.iv.x1 - 1'b1;
	assign l_raw = k_raw + item_i.ik.iv.x2;

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			item_q.status <= BUBBLE;
		end else if (!stall_i) begin
			item_q        <= item_i;
			item_q.status <= status_d;
			occ_k_q       <= correct_bound(k_raw, primary_i);
			occ_l_q       <= correct_bound(l_raw, primary_i);
		end
	end

	assign item_o  = item_q;
	assign occ_k_o = occ_k_q; // request port, result due OCC_LATENCY later
	assign occ_l_o = occ_l_q;

endmodule

// ==== hw/fwd_extend_pkg.sv ====
package fwd_extend_pkg;

	// ----------------------------------------------------------------------
	// sizes and latency
	localparam int SEQ_LEN     = 101; // read length
	localparam int READ_NUM_W  = 8;
	localparam int POS_W       = 7;   // positions and curr pointer
	localparam int BOUND_W     = 64;  // interval values
	localparam int ADDR_W      = 32;  // dram line address
	localparam int OCC_LATENCY = 12;  // occurrence unit, request to result

	// ----------------------------------------------------------------------
	// encodings
	typedef enum logic [5:0] {
		F_INIT  = 6'h00,
		F_RUN   = 6'h01,
		F_BREAK = 6'h02,
		BCK_INI = 6'h04,
		BCK_RUN = 6'h05,
		BCK_END = 6'h06,
		BUBBLE  = 6'h30  // empty slot
	} fwd_status_e;

	typedef enum logic [7:0] {
		BASE_A = 8'd0,
		BASE_C = 8'd1,
		BASE_G = 8'd2,
		BASE_T = 8'd3   // anything above is an ambiguous base
	} base_e;

	// ----------------------------------------------------------------------
	// item and port bundles
	typedef struct packed {
		logic [BOUND_W-1:0] x2; // interval size
		logic [BOUND_W-1:0] x1;
		logic [BOUND_W-1:0] x0;
	} bi_interval_t;

	// packs as info, x2, x1, x0, the curr queue word layout
	typedef struct packed {
		logic [BOUND_W-1:0] info; // low bits hold the return position
		bi_interval_t       iv;
	} ik_t;

	typedef struct packed {
		fwd_status_e         status;
		base_e               query;    // current base only
		logic [POS_W-1:0]    ptr_curr; // curr queue write pointer
		logic [READ_NUM_W-1:0] read_num;
		ik_t                 ik;
		logic [POS_W-1:0]    forward_i;
		logic [POS_W-1:0]    min_intv;
		logic [POS_W-1:0]    backward_x; // carried only
	} fwd_item_t;

	typedef bi_interval_t [3:0] occ_result_t; // ok[] indexed by base code

	typedef struct packed {
		logic                  we;
		logic [READ_NUM_W-1:0] read_num;
		logic [POS_W-1:0]      addr;
		ik_t                   data;
	} curr_write_t;

	typedef struct packed {
		fwd_status_e           status;
		logic [READ_NUM_W-1:0] read_num;
		logic [POS_W-1:0]      position;
	} query_req_t;

	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] addr_k;
		logic [ADDR_W-1:0] addr_l;
	} dram_req_t;

	// ----------------------------------------------------------------------
	// bound helpers
	function automatic logic [BOUND_W-1:0] correct_bound(input logic [BOUND_W-1:0] raw,
			input logic [BOUND_W-1:0] primary);
		return (raw >= primary) ? raw - 1'b1 : raw; // skip the primary row
	endfunction

	function automatic logic [ADDR_W-1:0] line_addr(input logic [BOUND_W-1:0] bound);
		return {bound[34:7], 4'b0000}; // 128-entry occ line
	endfunction

endpackage
